//--- design/alu_array_pkg.sv
package alu_array_pkg;

	// data word carried by operands and results
	typedef logic [31:0] word_t;

	// AXI4-Lite byte address
	typedef logic [7:0] addr_t;

	// AXI response code
	typedef logic [1:0] resp_t;

	// register offset inside one lane window
	typedef logic [3:0] reg_off_t;

	// shift amount, only the low five bits of src2
	typedef logic [4:0] shamt_t;

	// lane number
	typedef logic [1:0] lane_idx_t;

	localparam resp_t OKAY   = 2'b00;
	localparam resp_t SLVERR = 2'b10;

	localparam int NUM_LANES = 4;

	// each lane owns 16 bytes starting at lane * 16
	localparam reg_off_t REG_SRC1   = 4'h0;
	localparam reg_off_t REG_SRC2   = 4'h4;
	// writing the op launches the lane
	localparam reg_off_t REG_OP     = 4'h8;
	localparam reg_off_t REG_RESULT = 4'hc;

	// status word sits just past the last lane window
	// done in 3:0, zero in 7:4, sign in 11:8
	localparam addr_t REG_STATUS = 8'h40;

	// op codes follow the original ALU control encoding
	// 11 to 15 are not defined and give zero
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		SLL  = 4'd2,
		SLT  = 4'd3,
		SLTU = 4'd4,
		XOR  = 4'd5,
		SRL  = 4'd6,
		SRA  = 4'd7,
		OR   = 4'd8,
		AND  = 4'd9,
		PASS = 4'd10
	} alu_op_t;

	// dispatcher to lane, 69 bits
	typedef struct packed {
		logic    valid;
		alu_op_t op;
		word_t   src1;
		word_t   src2;
	} lane_issue_t;

	// lane to collector, 35 bits
	typedef struct packed {
		logic  valid;
		word_t result;
		logic  zero;
		logic  sign;
	} lane_result_t;

endpackage

//--- design/alu_lane.sv
`timescale 1ns/10ps

module alu_lane
	import alu_array_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  lane_issue_t  issue,
	output lane_result_t result
);

	// combinational datapath
	word_t  alu_out;
	word_t  diff;
	shamt_t shamt;
	logic   sign_of_diff;
	logic   sign_next;

	// only five bits of shift, so amounts above 31 wrap
	assign shamt = issue.src2[4:0];

	// difference shared by sub and the sign flag of the compares
	assign diff = issue.src1 - issue.src2;

	always_comb begin
		case (issue.op)
			ADD:  alu_out = issue.src1 + issue.src2;
			SUB:  alu_out = diff;
			SLL:  alu_out = issue.src1 << shamt;
			// signed compare
			SLT:  alu_out = word_t'($signed(issue.src1) < $signed(issue.src2));
			// unsigned compare
			SLTU: alu_out = word_t'(issue.src1 < issue.src2);
			XOR:  alu_out = issue.src1 ^ issue.src2;
			SRL:  alu_out = issue.src1 >> shamt;
			// arithmetic shift keeps the top bit of src1
			SRA:  alu_out = word_t'($signed(issue.src1) >>> shamt);
			OR:   alu_out = issue.src1 | issue.src2;
			AND:  alu_out = issue.src1 & issue.src2;
			PASS: alu_out = issue.src2;
			// undefined codes
			default: alu_out = '0;
		endcase
	end

	// sub and the compares report the sign of src1 - src2
	assign sign_of_diff = (issue.op == SUB) || (issue.op == SLT) || (issue.op == SLTU);

	// everything else reports the top bit of the result
	assign sign_next = sign_of_diff ? diff[31] : alu_out[31];

	// one cycle from issue to result
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
		end else begin
			// valid is a single pulse, one cycle after issue
			result.valid <= issue.valid;
			if (issue.valid) begin
				result.result <= alu_out;
				result.zero   <= (alu_out == '0);
				result.sign   <= sign_next;
			end
		end
	end

endmodule

//--- design/alu_dispatch.sv
`timescale 1ns/10ps

module alu_dispatch
	import alu_array_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  addr_t       awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  word_t       wdata,
	input  logic        wvalid,
	output logic        wready,
	output resp_t       bresp,
	output logic        bvalid,
	input  logic        bready,
	output lane_issue_t issue [NUM_LANES]
);

	// address decode
	lane_idx_t wr_lane;
	reg_off_t  wr_off;
	logic      wr_in_lanes;
	logic      wr_src1;
	logic      wr_src2;
	logic      wr_op;
	logic      wr_ok;

	// handshake
	logic accept;
	logic wr_fire;

	// per lane launch request
	logic [NUM_LANES-1:0] op_hit;

	// operands held until the op write
	word_t src1_q [NUM_LANES];
	word_t src2_q [NUM_LANES];

	assign wr_lane     = awaddr[5:4];
	assign wr_off      = awaddr[3:0];
	assign wr_in_lanes = (awaddr[7:4] < NUM_LANES);

	assign wr_src1 = wr_in_lanes && (wr_off == REG_SRC1);
	assign wr_src2 = wr_in_lanes && (wr_off == REG_SRC2);
	assign wr_op   = wr_in_lanes && (wr_off == REG_OP);

	// result, status and holes in the map are not writable
	assign wr_ok = wr_src1 || wr_src2 || wr_op;

	// ready goes high for a single cycle, never while B is outstanding
	assign accept  = !awready && awvalid && wvalid && !bvalid;
	assign wr_fire = awready && awvalid && wvalid;

	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			op_hit[l] = wr_fire && wr_op && (wr_lane == lane_idx_t'(l));
		end
	end

	// AW and W are accepted together
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready  <= 1'b0;
		end else begin
			awready <= accept;
			wready  <= accept;
		end
	end

	// B response, held until bready
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
			bresp  <= OKAY;
		end else if (wr_fire) begin
			bvalid <= 1'b1;
			bresp  <= wr_ok ? OKAY : SLVERR;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	// operand registers
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				src1_q[l] <= '0;
				src2_q[l] <= '0;
			end
		end else if (wr_fire) begin
			if (wr_src1)
				src1_q[wr_lane] <= wdata;
			if (wr_src2)
				src2_q[wr_lane] <= wdata;
		end
	end

	// issue pulse one cycle after the op handshake
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int l = 0; l < NUM_LANES; l++)
				issue[l] <= '0;
		end else begin
			for (int l = 0; l < NUM_LANES; l++) begin
				issue[l].valid <= op_hit[l];
				if (op_hit[l]) begin
					// op code is the low nibble of the written word
					issue[l].op   <= alu_op_t'(wdata[3:0]);
					issue[l].src1 <= src1_q[l];
					issue[l].src2 <= src2_q[l];
				end
			end
		end
	end

endmodule

//--- design/alu_collect.sv
`timescale 1ns/10ps

module alu_collect
	import alu_array_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  lane_result_t result [NUM_LANES],
	input  addr_t        araddr,
	input  logic         arvalid,
	output logic         arready,
	output word_t        rdata,
	output resp_t        rresp,
	output logic         rvalid,
	input  logic         rready
);

	// read decode
	lane_idx_t rd_lane;
	reg_off_t  rd_off;
	logic      rd_result;
	logic      rd_status;
	logic      rd_fire;

	// stored lane state
	word_t                res_q [NUM_LANES];
	logic [NUM_LANES-1:0] done_q;
	logic [NUM_LANES-1:0] zero_q;
	logic [NUM_LANES-1:0] sign_q;

	// assembled status word
	word_t status_word;

	assign rd_lane   = araddr[5:4];
	assign rd_off    = araddr[3:0];
	assign rd_result = (araddr[7:4] < NUM_LANES) && (rd_off == REG_RESULT);
	assign rd_status = (araddr == REG_STATUS);

	assign rd_fire = arready && arvalid;

	// done, zero and sign, one bit per lane in each field
	always_comb begin
		status_word = '0;
		status_word[NUM_LANES-1:0]               = done_q;
		status_word[2*NUM_LANES-1:NUM_LANES]     = zero_q;
		status_word[3*NUM_LANES-1:2*NUM_LANES]   = sign_q;
	end

	// arready pulses for one cycle, only with no R pending
	always_ff @(posedge clk) begin
		if (!rst_n)
			arready <= 1'b0;
		else
			arready <= !arready && arvalid && !rvalid;
	end

	// R response, data frozen until rready
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
			rdata  <= '0;
			rresp  <= OKAY;
		end else if (rd_fire) begin
			rvalid <= 1'b1;
			if (rd_result) begin
				rdata <= res_q[rd_lane];
				rresp <= OKAY;
			end else if (rd_status) begin
				rdata <= status_word;
				rresp <= OKAY;
			end else begin
				// anything else in the map is write only or empty
				rdata <= '0;
				rresp <= SLVERR;
			end
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// lane results are captured whatever the bus is doing
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done_q <= '0;
			zero_q <= '0;
			sign_q <= '0;
			for (int l = 0; l < NUM_LANES; l++)
				res_q[l] <= '0;
		end else begin
			for (int l = 0; l < NUM_LANES; l++) begin
				// reading the result consumes done, result stays
				if (rd_fire && rd_result && (rd_lane == lane_idx_t'(l)))
					done_q[l] <= 1'b0;
				// a new result in the same cycle wins over the clear
				if (result[l].valid) begin
					done_q[l] <= 1'b1;
					res_q[l]  <= result[l].result;
					zero_q[l] <= result[l].zero;
					sign_q[l] <= result[l].sign;
				end
			end
		end
	end

endmodule

//--- design/alu_array_top.sv
`timescale 1ns/10ps

module alu_array_top
	import alu_array_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t awaddr,
	input  logic  awvalid,
	output logic  awready,
	input  word_t wdata,
	input  logic  wvalid,
	output logic  wready,
	output resp_t bresp,
	output logic  bvalid,
	input  logic  bready,
	input  addr_t araddr,
	input  logic  arvalid,
	output logic  arready,
	output word_t rdata,
	output resp_t rresp,
	output logic  rvalid,
	input  logic  rready
);

	// one issue and one result per lane
	lane_issue_t  issue  [NUM_LANES];
	lane_result_t result [NUM_LANES];

	// write side and operand storage
	alu_dispatch alu_dispatch_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.issue   (issue)
	);

	// lanes run independently of each other
	for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
		alu_lane alu_lane_i (
			.clk    (clk),
			.rst_n  (rst_n),
			.issue  (issue[l]),
			.result (result[l])
		);
	end

	// read side with result store and status
	alu_collect alu_collect_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.result  (result),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

endmodule

//--- tests/alu_array_monitor.sv
`timescale 1ns/10ps

module alu_array_monitor
	import alu_array_pkg::*;
(
	input logic  clk,
	input logic  rst_n,
	input logic  awready,
	input logic  wready,
	input logic  bvalid,
	input logic  bready,
	input resp_t bresp,
	input logic  rvalid,
	input logic  rready,
	input word_t rdata,
	input resp_t rresp
);

	// expected responses in the order the host issues them
	resp_t b_resp_q [$];
	string b_tag_q  [$];
	word_t r_data_q [$];
	resp_t r_resp_q [$];
	string r_tag_q  [$];

	int checks = 0;
	int errors = 0;

	// scratch for the beat being compared
	resp_t b_exp;
	string b_tag;
	word_t r_exp_data;
	resp_t r_exp_resp;
	string r_tag;
	logic  r_bad;

	task automatic expect_write(input resp_t resp, input string tag);
		b_resp_q.push_back(resp);
		b_tag_q.push_back(tag);
	endtask

	task automatic expect_read(input word_t data, input resp_t resp, input string tag);
		r_data_q.push_back(data);
		r_resp_q.push_back(resp);
		r_tag_q.push_back(tag);
	endtask

	function automatic int pending();
		return b_resp_q.size() + r_resp_q.size();
	endfunction

	// AW and W are taken in the same cycle, so wready follows awready exactly
	always @(negedge clk) begin
		if (rst_n && (wready !== awready)) begin
			errors++;
			$display("MISMATCH wready got 0x%h expected 0x%h", wready, awready);
		end
	end

	// a beat completes where valid and ready are both high at the falling edge
	always @(negedge clk) begin
		if (rst_n && bvalid && bready) begin
			checks++;
			if (b_resp_q.size() == 0) begin
				errors++;
				$display("write response arrived with none expected");
			end else begin
				b_exp = b_resp_q.pop_front();
				b_tag = b_tag_q.pop_front();
				if (bresp !== b_exp) begin
					errors++;
					$display("MISMATCH bresp got 0x%h expected 0x%h (%s)", bresp, b_exp, b_tag);
				end else begin
					$display("ok %s bresp=0x%h", b_tag, bresp);
				end
			end
		end
	end

	always @(negedge clk) begin
		if (rst_n && rvalid && rready) begin
			checks++;
			if (r_resp_q.size() == 0) begin
				errors++;
				$display("read response arrived with none expected");
			end else begin
				r_exp_data = r_data_q.pop_front();
				r_exp_resp = r_resp_q.pop_front();
				r_tag      = r_tag_q.pop_front();
				r_bad      = 1'b0;
				if (rdata !== r_exp_data) begin
					r_bad = 1'b1;
					$display("MISMATCH rdata got 0x%h expected 0x%h (%s)",
						rdata, r_exp_data, r_tag);
				end
				if (rresp !== r_exp_resp) begin
					r_bad = 1'b1;
					$display("MISMATCH rresp got 0x%h expected 0x%h (%s)",
						rresp, r_exp_resp, r_tag);
				end
				if (r_bad)
					errors++;
				else
					$display("ok %s rdata=0x%h rresp=0x%h", r_tag, rdata, rresp);
			end
		end
	end

endmodule

//--- tests/alu_array_checker.sv
`timescale 1ns/10ps

module alu_array_checker
	import alu_array_pkg::*;
(
	input logic         clk,
	input logic         rst_n,
	input logic         awready,
	input logic         bvalid,
	input logic         bready,
	input resp_t        bresp,
	input logic         rvalid,
	input logic         rready,
	input word_t        rdata,
	input lane_issue_t  issue  [NUM_LANES],
	input lane_result_t result [NUM_LANES]
);

	// B stays up with the same code until the host takes it
	a_b_stable: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("bvalid dropped or bresp changed before bready");

	// same for R and its data
	a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("rvalid dropped or rdata changed before rready");

	// no new write is accepted while B is outstanding
	a_aw_blocked: assert property (@(posedge clk) disable iff (!rst_n)
		!(awready && bvalid))
		else $error("awready high with a write response pending");

	// each lane answers exactly one cycle after its issue
	for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
		a_lane_latency: assert property (@(posedge clk) disable iff (!rst_n)
			result[l].valid == $past(issue[l].valid))
			else $error("lane %0d result valid not one cycle after issue", l);
	end

endmodule

bind alu_array_top alu_array_checker alu_array_checker_i (
	.clk     (clk),
	.rst_n   (rst_n),
	.awready (awready),
	.bvalid  (bvalid),
	.bready  (bready),
	.bresp   (bresp),
	.rvalid  (rvalid),
	.rready  (rready),
	.rdata   (rdata),
	.issue   (issue),
	.result  (result)
);

//--- tests/alu_array_tb.sv
`timescale 1ns/10ps

module alu_array_tb
	import alu_array_pkg::*;
();

	// polls of a ready or valid before giving up
	localparam int WAIT_LIMIT = 40;
	localparam int NUM_VECS   = 24;

	// op is a raw nibble in the table row so undefined codes fit
	typedef struct packed {
		lane_idx_t   lane;
		logic [3:0]  op;
		word_t       src1;
		word_t       src2;
		word_t       result;
		logic        zero;
		logic        sign;
	} vec_t;

	logic  clk;
	logic  rst_n;
	addr_t awaddr;
	logic  awvalid;
	logic  awready;
	word_t wdata;
	logic  wvalid;
	logic  wready;
	resp_t bresp;
	logic  bvalid;
	logic  bready;
	addr_t araddr;
	logic  arvalid;
	logic  arready;
	word_t rdata;
	resp_t rresp;
	logic  rvalid;
	logic  rready;

	vec_t vec_tab [NUM_VECS];

	// expected lane state behind the status word
	logic [NUM_LANES-1:0] done_m;
	logic [NUM_LANES-1:0] zero_m;
	logic [NUM_LANES-1:0] sign_m;
	word_t                res_m [NUM_LANES];

	alu_array_top alu_array_top_i (.*);

	// watches wready, B and R and does all the comparing
	alu_array_monitor alu_array_monitor_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic addr_t lane_addr(input lane_idx_t lane, input reg_off_t off);
		return {2'b00, lane, off};
	endfunction

	// done in 3:0, zero in 7:4, sign in 11:8
	function automatic word_t status_expect();
		word_t s;
		s = '0;
		s[3:0]  = done_m;
		s[7:4]  = zero_m;
		s[11:8] = sign_m;
		return s;
	endfunction

	task automatic print_counts();
		$display("checks %0d, errors %0d, responses never seen %0d",
			alu_array_monitor_i.checks, alu_array_monitor_i.errors,
			alu_array_monitor_i.pending());
	endtask

	task automatic fail_timeout(input string what);
		$display("timeout: %s within %0d cycles", what, WAIT_LIMIT);
		print_counts();
		$display("ERRORS FOUND");
		$finish;
	endtask

	// sel 0 awready, 1 bvalid, 2 arready, 3 rvalid; returns at a falling edge
	task automatic wait_until(input int sel, input string what);
		int   n;
		logic hit;
		n   = 0;
		hit = 1'b0;
		while (!hit) begin
			@(negedge clk);
			case (sel)
				0:       hit = awready;
				1:       hit = bvalid;
				2:       hit = arready;
				default: hit = rvalid;
			endcase
			n++;
			if (!hit && n > WAIT_LIMIT)
				fail_timeout(what);
		end
	endtask

	// keep the response waiting for 0 to 7 cycles, then take it
	task automatic hold_then_accept(input int sel);
		int hold;
		hold = int'($urandom % 8);
		repeat (hold) @(posedge clk);
		@(posedge clk);
		if (sel == 0)
			bready <= 1'b1;
		else
			rready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
		rready <= 1'b0;
	endtask

	task automatic axi_write(input addr_t addr, input word_t data, input resp_t resp,
		input string tag);
		alu_array_monitor_i.expect_write(resp, tag);
		@(posedge clk);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		wait_until(0, "awready never rose");
		// handshake on the next edge
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		wait_until(1, "bvalid never rose");
		hold_then_accept(0);
	endtask

	task automatic axi_read(input addr_t addr, input word_t data, input resp_t resp,
		input string tag);
		alu_array_monitor_i.expect_read(data, resp, tag);
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		wait_until(2, "arready never rose");
		@(posedge clk);
		arvalid <= 1'b0;
		wait_until(3, "rvalid never rose");
		hold_then_accept(1);
	endtask

	task automatic note_result(input vec_t v);
		done_m[v.lane] = 1'b1;
		zero_m[v.lane] = v.zero;
		sign_m[v.lane] = v.sign;
		res_m[v.lane]  = v.result;
	endtask

	// reading the result consumes done but keeps the value
	task automatic read_result(input lane_idx_t lane, input string tag);
		axi_read(lane_addr(lane, REG_RESULT), res_m[lane], OKAY, tag);
		done_m[lane] = 1'b0;
	endtask

	task automatic run_entry(input int i);
		vec_t  v;
		string t;
		v = vec_tab[i];
		t = $sformatf("vec %0d op %0d lane %0d", i, v.op, v.lane);
		axi_write(lane_addr(v.lane, REG_SRC1), v.src1, OKAY, {t, " src1"});
		axi_write(lane_addr(v.lane, REG_SRC2), v.src2, OKAY, {t, " src2"});
		axi_write(lane_addr(v.lane, REG_OP), word_t'(v.op), OKAY, {t, " op"});
		note_result(v);
		// the B response alone takes the op handshake past 3 cycles
		axi_read(REG_STATUS, status_expect(), OKAY, {t, " status"});
		read_result(v.lane, {t, " result"});
		axi_read(REG_STATUS, status_expect(), OKAY, {t, " status after read"});
	endtask

	initial begin
		void'($urandom(32'hd09f));
		rst_n   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		done_m  = '0;
		zero_m  = '0;
		sign_m  = '0;
		for (int l = 0; l < NUM_LANES; l++)
			res_m[l] = '0;

		// lane, op, src1, src2, result, zero, sign
		vec_tab[0]  = '{2'd0, ADD,  32'h0000_0005, 32'h0000_0007, 32'h0000_000c, 1'b0, 1'b0};
		vec_tab[1]  = '{2'd1, ADD,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b1, 1'b0};
		vec_tab[2]  = '{2'd2, SUB,  32'h0000_0003, 32'h0000_0005, 32'hffff_fffe, 1'b0, 1'b1};
		vec_tab[3]  = '{2'd3, SUB,  32'h1234_5678, 32'h1234_5678, 32'h0000_0000, 1'b1, 1'b0};
		vec_tab[4]  = '{2'd0, SLL,  32'h0000_0001, 32'h0000_0004, 32'h0000_0010, 1'b0, 1'b0};
		// shift amounts above 31 keep only bits 4:0
		vec_tab[5]  = '{2'd1, SLL,  32'h0000_0003, 32'h0000_0021, 32'h0000_0006, 1'b0, 1'b0};
		vec_tab[6]  = '{2'd2, SRL,  32'h8000_0000, 32'h0000_001f, 32'h0000_0001, 1'b0, 1'b0};
		vec_tab[7]  = '{2'd3, SRL,  32'hf000_0000, 32'h0000_0024, 32'h0f00_0000, 1'b0, 1'b0};
		vec_tab[8]  = '{2'd0, SRA,  32'h8000_0000, 32'h0000_0004, 32'hf800_0000, 1'b0, 1'b1};
		vec_tab[9]  = '{2'd1, SRA,  32'h8000_0000, 32'h0000_003f, 32'hffff_ffff, 1'b0, 1'b1};
		vec_tab[10] = '{2'd2, SRA,  32'h4000_0000, 32'h0000_0002, 32'h1000_0000, 1'b0, 1'b0};
		// compares flag the sign of src1 - src2, not of the result
		vec_tab[11] = '{2'd3, SLT,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, 1'b0, 1'b1};
		vec_tab[12] = '{2'd0, SLT,  32'h7fff_ffff, 32'h8000_0000, 32'h0000_0000, 1'b1, 1'b1};
		vec_tab[13] = '{2'd1, SLT,  32'h8000_0000, 32'h7fff_ffff, 32'h0000_0001, 1'b0, 1'b0};
		vec_tab[14] = '{2'd2, SLTU, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b1, 1'b1};
		vec_tab[15] = '{2'd3, SLTU, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0001, 1'b0, 1'b0};
		vec_tab[16] = '{2'd0, SLTU, 32'h0000_0005, 32'h0000_0005, 32'h0000_0000, 1'b1, 1'b0};
		vec_tab[17] = '{2'd1, XOR,  32'hff00_ff00, 32'h0f0f_0f0f, 32'hf00f_f00f, 1'b0, 1'b1};
		vec_tab[18] = '{2'd2, XOR,  32'ha5a5_a5a5, 32'ha5a5_a5a5, 32'h0000_0000, 1'b1, 1'b0};
		vec_tab[19] = '{2'd3, OR,   32'h1234_0000, 32'h0000_5678, 32'h1234_5678, 1'b0, 1'b0};
		vec_tab[20] = '{2'd0, AND,  32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'h00f0_00f0, 1'b0, 1'b0};
		vec_tab[21] = '{2'd1, AND,  32'h8000_0001, 32'h8000_0003, 32'h8000_0001, 1'b0, 1'b1};
		vec_tab[22] = '{2'd2, PASS, 32'h1111_1111, 32'hcafe_f00d, 32'hcafe_f00d, 1'b0, 1'b1};
		// undefined op code
		vec_tab[23] = '{2'd3, 4'hd, 32'h1234_5678, 32'h9abc_def0, 32'h0000_0000, 1'b1, 1'b0};

		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		for (int i = 0; i < NUM_VECS; i++)
			run_entry(i);

		// operands for all lanes first, then the four ops back to back
		for (int k = 4; k < 8; k++) begin
			axi_write(lane_addr(vec_tab[k].lane, REG_SRC1), vec_tab[k].src1, OKAY, "burst src1");
			axi_write(lane_addr(vec_tab[k].lane, REG_SRC2), vec_tab[k].src2, OKAY, "burst src2");
		end
		for (int k = 4; k < 8; k++) begin
			axi_write(lane_addr(vec_tab[k].lane, REG_OP), word_t'(vec_tab[k].op), OKAY,
				"burst op");
			note_result(vec_tab[k]);
		end
		axi_read(REG_STATUS, status_expect(), OKAY, "burst status");
		for (int l = 0; l < NUM_LANES; l++)
			read_result(lane_idx_t'(l), $sformatf("burst result lane %0d", l));
		axi_read(REG_STATUS, status_expect(), OKAY, "burst status after reads");

		// nothing outside src1, src2 and op is writable
		axi_write(lane_addr(2'd0, REG_RESULT), 32'hdead_beef, SLVERR, "write result reg");
		axi_write(REG_STATUS, 32'hffff_ffff, SLVERR, "write status reg");
		axi_write(8'h22, 32'h0000_0001, SLVERR, "write hole in lane");
		axi_write(8'h88, 32'h0000_0009, SLVERR, "write past map");
		axi_read(lane_addr(2'd1, REG_SRC1), '0, SLVERR, "read src1 reg");
		axi_read(lane_addr(2'd2, REG_OP), '0, SLVERR, "read op reg");
		axi_read(8'h90, '0, SLVERR, "read past map");
		axi_read(REG_STATUS, status_expect(), OKAY, "status after bad access");
		for (int l = 0; l < NUM_LANES; l++)
			read_result(lane_idx_t'(l), $sformatf("result kept lane %0d", l));

		print_counts();
		if (alu_array_monitor_i.errors == 0 && alu_array_monitor_i.pending() == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- list.f
design/alu_array_pkg.sv
design/alu_lane.sv
design/alu_dispatch.sv
design/alu_collect.sv
design/alu_array_top.sv
tests/alu_array_monitor.sv
tests/alu_array_checker.sv
tests/alu_array_tb.sv

//--- Bender.yml
package:
  name: alu_array

sources:
  # design, package first
  - files:
      - design/alu_array_pkg.sv
      - design/alu_lane.sv
      - design/alu_dispatch.sv
      - design/alu_collect.sv
      - design/alu_array_top.sv

  # testbench, monitor and bound assertions
  - target: test
    files:
      - tests/alu_array_monitor.sv
      - tests/alu_array_checker.sv
      - tests/alu_array_tb.sv
